// ==== logic/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_XLEN 32
`define RV_REG_AW 5
`define RV_NUM_REGS 32

`define RV_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== logic/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_OR     = 4'd4,
        ALU_AND    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_PASS_B = 4'd9
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        opcode_e               opcode;
    } s_type_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_e               opcode;
    } b_type_t;

    // Also carries the scrambled JAL offset
    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [`RV_REG_AW-1:0] rd;
        opcode_e               opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
    } instr_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    is_load;
        logic    is_store;
        logic    is_branch_eq;
        logic    is_branch_ne;
        logic    is_jal;
        logic    wb_en;
    } ctrl_t;

endpackage

// ==== logic/rv_stage_if.sv ====
`include "rv_settings.svh"

interface dec_ex_if;
    logic                  valid;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_REG_AW-1:0] rd;
    rv_pkg::ctrl_t         ctrl;

    modport src (output valid, pc, rs1_addr, rs2_addr, rs1_val, rs2_val, imm, rd, ctrl);
    modport dst (input valid, pc, rs1_addr, rs2_addr, rs1_val, rs2_val, imm, rd, ctrl);
endinterface

interface ex_mem_if;
    logic                  valid;
    logic [`RV_XLEN-1:0]   result;
    logic [`RV_XLEN-1:0]   store_data;
    logic [`RV_REG_AW-1:0] rd;
    rv_pkg::ctrl_t         ctrl;

    modport src (output valid, result, store_data, rd, ctrl);
    modport dst (input valid, result, store_data, rd, ctrl);
endinterface

interface wb_if;
    logic                  wr_en;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   value;

    modport src (output wr_en, rd, value);
    modport dst (input wr_en, rd, value);
    // Execute snoops the same bus for forwarding
    modport fwd (input wr_en, rd, value);
endinterface

// ==== logic/rv_fetch_decode.sv ====
`include "rv_settings.svh"

module rv_fetch_decode (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic [`RV_XLEN-1:0]   imem_addr,
    input  logic [`RV_XLEN-1:0]   imem_data,
    input  logic                  taken,
    input  logic [`RV_XLEN-1:0]   target,
    output logic [`RV_REG_AW-1:0] rs1_addr,
    output logic [`RV_REG_AW-1:0] rs2_addr,
    input  logic [`RV_XLEN-1:0]   rs1_val,
    input  logic [`RV_XLEN-1:0]   rs2_val,
    dec_ex_if.src                 dec_ex
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] if_id_pc;
    logic [`RV_XLEN-1:0] if_id_instr;
    rv_pkg::instr_u      ins;
    rv_pkg::ctrl_t       ctrl;
    rv_pkg::alu_op_e     alu_sel;
    logic [`RV_XLEN-1:0] imm;
    logic                alu_ok;
    logic                dec_ok;
    logic                use_rs1;
    logic                use_rs2;
    logic                load_use;
    logic                stall;

    assign imem_addr = pc;
    assign ins       = if_id_instr;
    assign rs1_addr  = ins.r.rs1;
    assign rs2_addr  = ins.r.rs2;

    // funct3 decode shared by OP and OP-IMM
    always_comb begin
        alu_ok = 1'b1;
        case (ins.r.funct3)
            3'b000: begin
                alu_sel = (ins.r.opcode == rv_pkg::OPC_OP && ins.r.funct7[5]) ?
                          rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            end
            3'b001: alu_sel = rv_pkg::ALU_SLL;
            3'b010: alu_sel = rv_pkg::ALU_SLT;
            3'b100: alu_sel = rv_pkg::ALU_XOR;
            3'b101: alu_sel = ins.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110: alu_sel = rv_pkg::ALU_OR;
            3'b111: alu_sel = rv_pkg::ALU_AND;
            default: begin
                alu_sel = rv_pkg::ALU_ADD;
                alu_ok  = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        dec_ok  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (ins.r.opcode)
            rv_pkg::OPC_LUI: begin
                imm          = {ins.u.imm_31_12, 12'b0};
                ctrl.alu_op  = rv_pkg::ALU_PASS_B;
                ctrl.use_imm = 1'b1;
                ctrl.wb_en   = 1'b1;
                dec_ok       = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                imm          = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
                ctrl.alu_op  = alu_sel;
                ctrl.use_imm = 1'b1;
                ctrl.wb_en   = 1'b1;
                use_rs1      = 1'b1;
                dec_ok       = alu_ok;
            end
            rv_pkg::OPC_OP: begin
                ctrl.alu_op = alu_sel;
                ctrl.wb_en  = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec_ok      = alu_ok;
            end
            rv_pkg::OPC_LOAD: begin
                imm          = {{20{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
                ctrl.use_imm = 1'b1;
                ctrl.is_load = 1'b1;
                ctrl.wb_en   = 1'b1;
                use_rs1      = 1'b1;
                dec_ok       = (ins.i.funct3 == 3'b010);
            end
            rv_pkg::OPC_STORE: begin
                imm           = {{20{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
                ctrl.use_imm  = 1'b1;
                ctrl.is_store = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                dec_ok        = (ins.s.funct3 == 3'b010);
            end
            rv_pkg::OPC_BRANCH: begin
                imm = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                       ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
                ctrl.is_branch_eq = (ins.b.funct3 == 3'b000);
                ctrl.is_branch_ne = (ins.b.funct3 == 3'b001);
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
                dec_ok            = ctrl.is_branch_eq || ctrl.is_branch_ne;
            end
            rv_pkg::OPC_JAL: begin
                // J-type offset rebuilt from the U view
                imm = {{11{ins.u.imm_31_12[19]}}, ins.u.imm_31_12[19], ins.u.imm_31_12[7:0],
                       ins.u.imm_31_12[8], ins.u.imm_31_12[18:9], 1'b0};
                ctrl.is_jal = 1'b1;
                ctrl.wb_en  = 1'b1;
                dec_ok      = 1'b1;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    assign load_use = dec_ex.valid && dec_ex.ctrl.is_load && dec_ex.rd != '0 &&
                      ((use_rs1 && ins.r.rs1 == dec_ex.rd) ||
                       (use_rs2 && ins.r.rs2 == dec_ex.rd));
    // Redirect wins over the hazard
    assign stall = load_use && !taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= `RV_RESET_PC;
            if_id_instr <= `RV_NOP;
        end else if (taken) begin
            pc          <= target;
            if_id_instr <= `RV_NOP;
        end else if (!stall) begin
            pc          <= pc + `RV_XLEN'(4);
            if_id_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_ex.valid <= 1'b0;
            dec_ex.ctrl  <= '0;
        end else if (taken || stall || !dec_ok) begin
            dec_ex.valid <= 1'b0;
            dec_ex.ctrl  <= '0;
        end else begin
            dec_ex.valid <= 1'b1;
            dec_ex.ctrl  <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        dec_ex.pc       <= if_id_pc;
        dec_ex.rs1_addr <= ins.r.rs1;
        dec_ex.rs2_addr <= ins.r.rs2;
        dec_ex.rs1_val  <= rs1_val;
        dec_ex.rs2_val  <= rs2_val;
        dec_ex.imm      <= imm;
        dec_ex.rd       <= ins.r.rd;
    end

endmodule

// ==== logic/rv_regfile.sv ====
`include "rv_settings.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    input  logic [`RV_REG_AW-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]   rs1_val,
    output logic [`RV_XLEN-1:0]   rs2_val,
    wb_if.dst                     wb
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wr_en && wb.rd != '0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // x0 first, then the write in flight
    assign rs1_val = (rs1_addr == '0) ? '0 :
                     (wb.wr_en && wb.rd == rs1_addr) ? wb.value : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 :
                     (wb.wr_en && wb.rd == rs2_addr) ? wb.value : regs[rs2_addr];

endmodule

// ==== logic/rv_execute.sv ====
`include "rv_settings.svh"

module rv_execute (
    input  logic                clk,
    input  logic                arst_n,
    dec_ex_if.dst               dec_ex,
    wb_if.fwd                   wb,
    output logic                taken,
    output logic [`RV_XLEN-1:0] target,
    ex_mem_if.src               ex_mem
);

    logic                mem_fwd;
    logic [`RV_XLEN-1:0] rs1_fwd;
    logic [`RV_XLEN-1:0] rs2_fwd;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] result;
    logic                is_eq;

    // A load in MEM has no data yet, the load-use stall covers it
    assign mem_fwd = ex_mem.valid && ex_mem.ctrl.wb_en && !ex_mem.ctrl.is_load &&
                     ex_mem.rd != '0;

    assign rs1_fwd = (mem_fwd && ex_mem.rd == dec_ex.rs1_addr) ? ex_mem.result :
                     (wb.wr_en && wb.rd == dec_ex.rs1_addr)    ? wb.value : dec_ex.rs1_val;
    assign rs2_fwd = (mem_fwd && ex_mem.rd == dec_ex.rs2_addr) ? ex_mem.result :
                     (wb.wr_en && wb.rd == dec_ex.rs2_addr)    ? wb.value : dec_ex.rs2_val;

    assign op_b = dec_ex.ctrl.use_imm ? dec_ex.imm : rs2_fwd;

    always_comb begin
        case (dec_ex.ctrl.alu_op)
            rv_pkg::ALU_ADD:    alu_y = rs1_fwd + op_b;
            rv_pkg::ALU_SUB:    alu_y = rs1_fwd - op_b;
            rv_pkg::ALU_SLT:    alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_fwd) < $signed(op_b)};
            rv_pkg::ALU_XOR:    alu_y = rs1_fwd ^ op_b;
            rv_pkg::ALU_OR:     alu_y = rs1_fwd | op_b;
            rv_pkg::ALU_AND:    alu_y = rs1_fwd & op_b;
            rv_pkg::ALU_SLL:    alu_y = rs1_fwd << op_b[4:0];
            rv_pkg::ALU_SRL:    alu_y = rs1_fwd >> op_b[4:0];
            rv_pkg::ALU_SRA:    alu_y = $unsigned($signed(rs1_fwd) >>> op_b[4:0]);
            rv_pkg::ALU_PASS_B: alu_y = op_b;
            default:            alu_y = '0;
        endcase
    end

    // Branch and jump resolution
    assign is_eq  = (rs1_fwd == rs2_fwd);
    assign taken  = dec_ex.valid && (dec_ex.ctrl.is_jal ||
                                     (dec_ex.ctrl.is_branch_eq && is_eq) ||
                                     (dec_ex.ctrl.is_branch_ne && !is_eq));
    assign target = dec_ex.pc + dec_ex.imm;

    // Link value for JAL
    assign result = dec_ex.ctrl.is_jal ? dec_ex.pc + `RV_XLEN'(4) : alu_y;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else begin
            ex_mem.valid <= dec_ex.valid;
            ex_mem.ctrl  <= dec_ex.valid ? dec_ex.ctrl : '0;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.result     <= result;
        ex_mem.store_data <= rs2_fwd;
        ex_mem.rd         <= dec_ex.rd;
    end

endmodule

// ==== logic/rv_mem_wb.sv ====
`include "rv_settings.svh"

module rv_mem_wb (
    input  logic                clk,
    input  logic                arst_n,
    ex_mem_if.dst               ex_mem,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic                dmem_we,
    output logic                dmem_re,
    input  logic [`RV_XLEN-1:0] dmem_rdata,
    wb_if.src                   wb
);

    logic [`RV_XLEN-1:0] wb_sel;
    logic                wr_en_next;

    // One address for both reads and writes
    assign dmem_addr  = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.valid && ex_mem.ctrl.is_store;
    assign dmem_re    = ex_mem.valid && ex_mem.ctrl.is_load;

    assign wb_sel     = ex_mem.ctrl.is_load ? dmem_rdata : ex_mem.result;
    assign wr_en_next = ex_mem.valid && ex_mem.ctrl.wb_en && ex_mem.rd != '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb.wr_en <= 1'b0;
        end else begin
            wb.wr_en <= wr_en_next;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd    <= ex_mem.rd;
        wb.value <= wb_sel;
    end

endmodule

// ==== logic/rv_core.sv ====
`include "rv_settings.svh"

module rv_core (
    input  logic                clk,
    input  logic                arst_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_data,
    output logic [`RV_XLEN-1:0] dmem_addr,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic                dmem_we,
    output logic                dmem_re,
    input  logic [`RV_XLEN-1:0] dmem_rdata
);

    logic                  taken;
    logic [`RV_XLEN-1:0]   target;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;

    dec_ex_if dec_ex_bus ();
    ex_mem_if ex_mem_bus ();
    wb_if     wb_bus ();

    rv_fetch_decode fetch_decode_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .taken     (taken),
        .target    (target),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .dec_ex    (dec_ex_bus.src)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .wb       (wb_bus.dst)
    );

    rv_execute execute_i (
        .clk    (clk),
        .arst_n (arst_n),
        .dec_ex (dec_ex_bus.dst),
        .wb     (wb_bus.fwd),
        .taken  (taken),
        .target (target),
        .ex_mem (ex_mem_bus.src)
    );

    rv_mem_wb mem_wb_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem_bus.dst),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .wb         (wb_bus.src)
    );

endmodule

// ==== dv/rv_core_asserts.sv ====
`include "rv_settings.svh"

module rv_core_asserts (
    input logic                clk,
    input logic                arst_n,
    input logic [`RV_XLEN-1:0] imem_addr,
    input logic [`RV_XLEN-1:0] imem_data,
    input logic [`RV_XLEN-1:0] dmem_addr,
    input logic                dmem_we,
    input logic                dmem_re,
    input logic                taken,
    input logic [`RV_XLEN-1:0] target
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic mem_fetched;

    // Set once a load or store opcode shows up at fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_fetched <= 1'b0;
        end else if (imem_data[6:0] == rv_pkg::OPC_LOAD ||
                     imem_data[6:0] == rv_pkg::OPC_STORE) begin
            mem_fetched <= 1'b1;
        end
    end

    reset_pc_a: assert property (@(posedge clk) $rose(arst_n) |-> imem_addr == `RV_RESET_PC)
        else begin
            $error("fetch did not start at the reset PC");
            fail_count++;
        end

    reset_quiet_a: assert property (@(posedge clk) !arst_n |-> !dmem_we && !dmem_re)
        else begin
            $error("data strobe high during reset");
            fail_count++;
        end

    early_quiet_a: assert property (@(posedge clk) disable iff (!arst_n)
        !mem_fetched |-> !dmem_we && !dmem_re)
        else begin
            $error("data strobe high before any load or store was fetched");
            fail_count++;
        end

    fetch_step_a: assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) && imem_addr != $past(imem_addr) |->
            imem_addr == $past(imem_addr) + 32'd4 ||
            ($past(taken) && imem_addr == $past(target)))
        else begin
            $error("fetch address moved by neither 4 nor a redirect");
            fail_count++;
        end

    redirect_a: assert property (@(posedge clk) disable iff (!arst_n)
        taken |=> imem_addr == $past(target))
        else begin
            $error("fetch address after a taken redirect is not the target");
            fail_count++;
        end

    strobe_excl_a: assert property (@(posedge clk) !(dmem_we && dmem_re))
        else begin
            $error("read and write strobes high together");
            fail_count++;
        end

    addr_align_a: assert property (@(posedge clk)
        (dmem_we || dmem_re) |-> dmem_addr[1:0] == 2'b00)
        else begin
            $error("data access to an unaligned address");
            fail_count++;
        end

endmodule

bind rv_core rv_core_asserts asserts_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dmem_addr (dmem_addr),
    .dmem_we   (dmem_we),
    .dmem_re   (dmem_re),
    .taken     (taken),
    .target    (target)
);

// ==== dv/rv_core_tb.sv ====
`include "rv_settings.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS      = 64;
    localparam int DONE_WORD      = 63;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                clk;
    logic                arst_n;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] imem_data;
    logic [`RV_XLEN-1:0] dmem_addr;
    logic [`RV_XLEN-1:0] dmem_wdata;
    logic                dmem_we;
    logic                dmem_re;
    logic [`RV_XLEN-1:0] dmem_rdata;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] xr [32];
    logic [31:0] exp_val [MEM_WORDS];
    bit          exp_set [MEM_WORDS];
    bit          seen [MEM_WORDS];
    string       exp_name [MEM_WORDS];
    logic [31:0] lfsr_state;
    int          n_instr;
    int          n_expected;

    rv_core dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    // Both memories answer in the same cycle
    assign imem_data  = imem[imem_addr[7:2]];
    // Read data only while the read strobe is up
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[7:2]] : '0;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Reference integer semantics of the OP and OP-IMM groups
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put(input logic [31:0] word);
        imem[n_instr] = word;
        n_instr++;
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 5'd0) begin
            xr[rd] = v;
        end
    endtask

    task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic alt;
        alt = (f3 == 3'b101) && imm[10];
        put(enc_i(imm, rs1, f3, rd, 7'b0010011));
        set_reg(rd, alu_model(f3, alt, xr[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic op_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        put(enc_r(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd));
        set_reg(rd, alu_model(f3, alt, xr[rs1], xr[rs2]));
    endtask

    task automatic load(input logic [4:0] rd, input logic [11:0] off);
        put(enc_i(off, 5'd0, 3'b010, rd, 7'b0000011));
        set_reg(rd, fill_word({20'b0, off}));
    endtask

    task automatic store(input string name, input logic [4:0] rs2, input logic [11:0] off);
        int w;
        w = int'(off[7:2]);
        put(enc_s(off, rs2, 5'd0));
        exp_val[w]  = xr[rs2];
        exp_set[w]  = 1'b1;
        exp_name[w] = name;
        n_expected++;
    endtask

    task automatic build_program();
        logic [31:0] r;
        lfsr_state = 32'hd666;
        n_instr    = 0;
        n_expected = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i]    = `RV_NOP;
            dmem[i]    = fill_word(32'(i * 4));
            exp_set[i] = 1'b0;
            seen[i]    = 1'b0;
        end
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        // Dependent chain, every operand comes from EX/MEM or MEM/WB
        r = rand_bits(12);
        op_imm(3'b000, 5'd1, 5'd0, r[11:0]);
        r = rand_bits(12);
        op_imm(3'b000, 5'd2, 5'd1, r[11:0]);
        op_reg(3'b000, 1'b0, 5'd3, 5'd2, 5'd1);
        op_reg(3'b000, 1'b1, 5'd4, 5'd3, 5'd2);
        op_reg(3'b100, 1'b0, 5'd5, 5'd4, 5'd3);
        op_reg(3'b001, 1'b0, 5'd6, 5'd5, 5'd1);
        store("fwd_sll", 5'd6, 12'h000);
        store("fwd_xor", 5'd5, 12'h004);
        store("fwd_sub", 5'd4, 12'h008);
        store("fwd_add", 5'd3, 12'h00c);
        // Load then immediate use
        r = rand_bits(4);
        load(5'd7, 12'h080 + {6'b0, r[3:0], 2'b00});
        op_reg(3'b000, 1'b0, 5'd8, 5'd7, 5'd6);
        store("load_use", 5'd8, 12'h010);
        // Taken BEQ, two marker stores behind it
        put(enc_b(13'd12, 5'd2, 5'd2, 3'b000));
        put(enc_s(12'h0e0, 5'd1, 5'd0));
        put(enc_s(12'h0e4, 5'd1, 5'd0));
        put(enc_b(13'd12, 5'd2, 5'd2, 3'b001));
        store("bne_fall", 5'd2, 12'h014);
        set_reg(5'd9, 32'(n_instr * 4 + 4));
        put(enc_j(21'd12, 5'd9));
        put(enc_s(12'h0e8, 5'd1, 5'd0));
        put(enc_s(12'h0ec, 5'd1, 5'd0));
        store("jal_link", 5'd9, 12'h018);
        store("done", 5'd2, 12'h0fc);
    endtask

    task automatic fail_now();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    initial begin
        int cycles;
        int n_seen;
        int w;
        bit done;
        arst_n = 1'b0;
        build_program();
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        cycles = 0;
        n_seen = 0;
        done   = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (dut_i.asserts_i.fail_count != 0) begin
                $display("A bound assertion on the core ports failed");
                fail_now();
            end
            if (dmem_we) begin
                w = int'(dmem_addr[7:2]);
                if (dmem_addr[31:8] != '0 || !exp_set[w] || seen[w]) begin
                    $display("Store to address %h was not expected", dmem_addr);
                    fail_now();
                end
                seen[w] = 1'b1;
                n_seen++;
                assert (dmem_wdata == exp_val[w]) else begin
                    $display("[ERROR] %s expected %h actual %h",
                             exp_name[w], exp_val[w], dmem_wdata);
                    fail_now();
                end
                dmem[w] = dmem_wdata;
                done    = (w == DONE_WORD);
            end
        end
        if (!done) begin
            $display("Timed out waiting for the store to the done address");
        end else if (n_seen != n_expected) begin
            $display("Only %0d of %0d expected stores arrived", n_seen, n_expected);
        end
        if (!done || n_seen != n_expected || dut_i.asserts_i.fail_count != 0) begin
            $display("SIMULATION FAILED");
            $fatal(1);
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/rv_pkg.sv
logic/rv_stage_if.sv
logic/rv_fetch_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_mem_wb.sv
logic/rv_core.sv
dv/rv_core_asserts.sv
dv/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv_core_tb -f vlog.f -o rv_core_sim

# Assertion errors must not end the run before the testbench reports
./obj_dir/rv_core_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "run failed, see sim.log"
exit 1
